// File: rtl/dcache_consts.svh
// ==========================================================
// Data cache sizes, address split and memory timing
// ==========================================================
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Byte address split as tag, index, offset
`define ADDR_BITS         12
`define TAG_BITS          3
`define SET_INDEX_BITS    5
`define BLOCK_OFFSET_BITS 4

// Cache organisation
`define ASSOCIATIVITY     2
`define SET_NUM           32
`define BLOCK_BYTES_NUM   16
`define BLOCK_SIZE_BITS   128

// Word geometry
`define WORD_BITS         32
`define WORDS_PER_BLOCK   4

// Backing memory, one entry per block address
`define MEM_BLOCKS        256

// Cycles from a memory strobe to mem_done
`define MEM_LATENCY       4

// Initial memory word = word address ^ key
`define MEM_INIT_KEY      32'hC0DE_5A17

`endif

// File: rtl/dcache_pkg.sv
// ==========================================================
// Shared cache types: block views and controller states
// ==========================================================
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    // One cache block, seen as words or as bytes
    typedef union packed {
        logic [`WORDS_PER_BLOCK-1:0][`WORD_BITS-1:0] words;
        logic [`BLOCK_BYTES_NUM-1:0][7:0]            bytes;
    } block_u;

    // Miss sequencing states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/dcache_sram.sv
// ==========================================================
// 2-way cache arrays: tag/valid/dirty/status and data,
// combinational hit, byte-masked store and victim fill
// ==========================================================
`default_nettype none

`include "dcache_consts.svh"

module dcache_sram (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       lookup_en,
    input  logic                                       store_we,
    input  logic                                       fill_we,
    input  logic [`TAG_BITS+`SET_INDEX_BITS-1:0]       block_addr,
    input  logic [`BLOCK_BYTES_NUM-1:0]                byte_en_blk,
    input  dcache_pkg::block_u                         wdata_blk,
    output logic                                       hit,
    output logic                                       victim_dirty,
    output logic [`TAG_BITS-1:0]                       victim_tag,
    output dcache_pkg::block_u                         rdata_blk
);

    localparam int WAY_BITS = $clog2(`ASSOCIATIVITY);

    // Control bits per set, one bit per way
    logic [`SET_NUM-1:0][`ASSOCIATIVITY-1:0] valid_arr;
    logic [`SET_NUM-1:0][`ASSOCIATIVITY-1:0] dirty_arr;
    logic [`SET_NUM-1:0][`ASSOCIATIVITY-1:0] status_arr;

    // Tag and data storage
    logic [`TAG_BITS-1:0] tag_arr  [`SET_NUM][`ASSOCIATIVITY];
    dcache_pkg::block_u   data_arr [`SET_NUM][`ASSOCIATIVITY];

    logic [`SET_INDEX_BITS-1:0] index;
    logic [`TAG_BITS-1:0]       tag;
    logic [`ASSOCIATIVITY-1:0]  hit_way;
    logic [WAY_BITS-1:0]        hit_idx;
    logic [WAY_BITS-1:0]        victim_idx;
    logic                       store_hit;

    assign index = block_addr[`SET_INDEX_BITS-1:0];
    assign tag   = block_addr[`TAG_BITS+`SET_INDEX_BITS-1:`SET_INDEX_BITS];

    // Mark a way as recently used; clear the others once all are set
    function automatic logic [`ASSOCIATIVITY-1:0] touch(
        input logic [`ASSOCIATIVITY-1:0] cur,
        input logic [WAY_BITS-1:0]       way
    );
        logic [`ASSOCIATIVITY-1:0] nxt;
        nxt      = cur;
        nxt[way] = 1'b1;
        if (&nxt) begin
            nxt      = '0;
            nxt[way] = 1'b1;
        end
        return nxt;
    endfunction

    // Tag compare across the set
    always_comb begin
        hit_way = '0;
        hit_idx = '0;
        for (int w = 0; w < `ASSOCIATIVITY; w++) begin
            hit_way[w] = lookup_en && valid_arr[index][w] && (tag_arr[index][w] == tag);
            if (hit_way[w]) begin
                hit_idx = WAY_BITS'(w);
            end
        end
    end

    // Victim is the lowest way with a clear status bit
    always_comb begin
        victim_idx = '0;
        for (int w = `ASSOCIATIVITY - 1; w >= 0; w--) begin
            if (!status_arr[index][w]) begin
                victim_idx = WAY_BITS'(w);
            end
        end
    end

    assign hit          = |hit_way;
    assign store_hit    = store_we && hit;
    assign victim_dirty = valid_arr[index][victim_idx] && dirty_arr[index][victim_idx];
    assign victim_tag   = tag_arr[index][victim_idx];

    // On a miss the victim block comes out, ready for writeback
    assign rdata_blk = hit ? data_arr[index][hit_idx] : data_arr[index][victim_idx];

    // Valid, dirty and replacement state
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_arr  <= '0;
            dirty_arr  <= '0;
            status_arr <= '0;
        end else if (store_hit) begin
            dirty_arr[index][hit_idx] <= 1'b1;
            status_arr[index]         <= touch(status_arr[index], hit_idx);
        end else if (fill_we) begin
            valid_arr[index][victim_idx] <= 1'b1;
            dirty_arr[index][victim_idx] <= 1'b0;
            status_arr[index]            <= touch(status_arr[index], victim_idx);
        end
    end

    // Block and tag writes
    always_ff @(posedge clk) begin
        if (store_hit) begin
            for (int b = 0; b < `BLOCK_BYTES_NUM; b++) begin
                if (byte_en_blk[b]) begin
                    data_arr[index][hit_idx].bytes[b] <= wdata_blk.bytes[b];
                end
            end
        end else if (fill_we) begin
            data_arr[index][victim_idx] <= wdata_blk;
            tag_arr[index][victim_idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_ctrl.sv
// ==========================================================
// Cache controller: lookup, dirty writeback, refill, respond
// ==========================================================
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req,
    input  logic                                 we,
    input  logic [`ADDR_BITS-1:0]                addr,
    input  logic [`WORD_BITS-1:0]                wdata,
    input  logic [`WORD_BITS/8-1:0]              byte_en,
    input  logic                                 sram_hit,
    input  logic                                 victim_dirty,
    input  logic [`TAG_BITS-1:0]                 victim_tag,
    input  dcache_pkg::block_u                   sram_rdata,
    input  logic                                 mem_done,
    input  logic [`BLOCK_SIZE_BITS-1:0]          mem_rdata,
    output logic                                 ready,
    output logic                                 done,
    output logic                                 hit,
    output logic [`WORD_BITS-1:0]                rdata,
    output logic                                 lookup_en,
    output logic                                 store_we,
    output logic                                 fill_we,
    output logic [`TAG_BITS+`SET_INDEX_BITS-1:0] block_addr,
    output logic [`BLOCK_BYTES_NUM-1:0]          byte_en_blk,
    output dcache_pkg::block_u                   wdata_blk,
    output logic                                 mem_rd,
    output logic                                 mem_wr,
    output logic [`TAG_BITS+`SET_INDEX_BITS-1:0] mem_block,
    output logic [`BLOCK_SIZE_BITS-1:0]          mem_wdata
);

    localparam int WORD_SEL_BITS = $clog2(`WORDS_PER_BLOCK);
    localparam int WORD_BYTES    = `WORD_BITS / 8;

    dcache_pkg::ctrl_state_e    state;
    logic                       req_we;
    logic [`ADDR_BITS-1:0]      req_addr;
    logic [`WORD_BITS-1:0]      req_wdata;
    logic [WORD_BYTES-1:0]      req_byte_en;
    logic                       hit_r;
    logic [`WORD_BITS-1:0]      rdata_r;
    logic [WORD_SEL_BITS-1:0]   word_sel;
    logic [`SET_INDEX_BITS-1:0] req_index;
    logic                       miss;
    dcache_pkg::block_u         store_blk;
    dcache_pkg::block_u         fill_blk;

    assign word_sel   = req_addr[`BLOCK_OFFSET_BITS-1 -: WORD_SEL_BITS];
    assign req_index  = req_addr[`BLOCK_OFFSET_BITS +: `SET_INDEX_BITS];
    assign block_addr = req_addr[`ADDR_BITS-1 -: `TAG_BITS+`SET_INDEX_BITS];

    assign ready     = (state == dcache_pkg::IDLE);
    assign done      = (state == dcache_pkg::RESPOND);
    assign lookup_en = (state == dcache_pkg::LOOKUP);
    assign miss      = lookup_en && !sram_hit;
    assign store_we  = lookup_en && sram_hit && req_we;
    assign fill_we   = (state == dcache_pkg::REFILL) && mem_done;

    // Writeback first if the victim is dirty; refill follows its completion
    assign mem_wr    = miss && victim_dirty;
    assign mem_rd    = (miss && !victim_dirty) || ((state == dcache_pkg::WRITEBACK) && mem_done);
    assign mem_block = mem_wr ? {victim_tag, req_index} : block_addr;
    assign mem_wdata = sram_rdata;

    // Store word placed in its slot, enables shifted to match
    always_comb begin
        store_blk                = '0;
        store_blk.words[word_sel] = req_wdata;
    end

    assign fill_blk    = mem_rdata;
    assign wdata_blk   = fill_we ? fill_blk : store_blk;
    assign byte_en_blk = {{(`BLOCK_BYTES_NUM-WORD_BYTES){1'b0}}, req_byte_en}
                         << (word_sel * WORD_BYTES);

    assign hit   = hit_r;
    assign rdata = rdata_r;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= dcache_pkg::IDLE;
            hit_r <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (req) begin
                        state <= dcache_pkg::LOOKUP;
                        hit_r <= 1'b1;
                    end
                end
                dcache_pkg::LOOKUP: begin
                    if (sram_hit) begin
                        state <= dcache_pkg::RESPOND;
                    end else begin
                        // Only a first lookup can miss
                        hit_r <= 1'b0;
                        state <= victim_dirty ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::WRITEBACK: begin
                    if (mem_done) begin
                        state <= dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::REFILL: begin
                    // Stores go back through lookup to merge bytes
                    if (mem_done) begin
                        state <= req_we ? dcache_pkg::LOOKUP : dcache_pkg::RESPOND;
                    end
                end
                dcache_pkg::RESPOND: state <= dcache_pkg::IDLE;
                default:             state <= dcache_pkg::IDLE;
            endcase
        end
    end

    // Request latch and load data
    always_ff @(posedge clk) begin
        if (ready && req) begin
            req_we      <= we;
            req_addr    <= addr;
            req_wdata   <= wdata;
            req_byte_en <= byte_en;
        end
        if (lookup_en && sram_hit) begin
            rdata_r <= sram_rdata.words[word_sel];
        end else if (fill_we) begin
            rdata_r <= fill_blk.words[word_sel];
        end
    end

endmodule

`default_nettype wire

// File: rtl/main_mem.sv
// ==========================================================
// Backing memory, block wide, fixed completion latency
// ==========================================================
`default_nettype none

`include "dcache_consts.svh"

module main_mem (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 mem_rd,
    input  logic                                 mem_wr,
    input  logic [`TAG_BITS+`SET_INDEX_BITS-1:0] mem_block,
    input  logic [`BLOCK_SIZE_BITS-1:0]          mem_wdata,
    output logic                                 mem_done,
    output logic [`BLOCK_SIZE_BITS-1:0]          mem_rdata
);

    localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);

    logic [`BLOCK_SIZE_BITS-1:0]          mem_arr [`MEM_BLOCKS];
    logic [`TAG_BITS+`SET_INDEX_BITS-1:0] pend_block;
    logic [CNT_BITS-1:0]                  cnt;
    logic                                 busy;

    // Each word holds its own word address mixed with the key
    initial begin
        for (int b = 0; b < `MEM_BLOCKS; b++) begin
            for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
                mem_arr[b][w*`WORD_BITS +: `WORD_BITS] = (b * `WORDS_PER_BLOCK + w) ^ `MEM_INIT_KEY;
            end
        end
    end

    // Writes land on the strobe edge
    always @(posedge clk) begin
        if (mem_wr) begin
            mem_arr[mem_block] <= mem_wdata;
        end
        if (mem_rd || mem_wr) begin
            pend_block <= mem_block;
        end
    end

    // Latency counter, restarted by any strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (mem_rd || mem_wr) begin
            busy <= 1'b1;
            cnt  <= CNT_BITS'(`MEM_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign mem_done  = busy && (cnt == '0);
    assign mem_rdata = mem_arr[pend_block];

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
// ==========================================================
// Data cache top: controller, cache arrays and main memory
// ==========================================================
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    we,
    input  logic [`ADDR_BITS-1:0]   addr,
    input  logic [`WORD_BITS-1:0]   wdata,
    input  logic [`WORD_BITS/8-1:0] byte_en,
    output logic                    ready,
    output logic                    done,
    output logic                    hit,
    output logic [`WORD_BITS-1:0]   rdata
);

    // Controller to arrays
    logic                                 lookup_en;
    logic                                 store_we;
    logic                                 fill_we;
    logic [`TAG_BITS+`SET_INDEX_BITS-1:0] block_addr;
    logic [`BLOCK_BYTES_NUM-1:0]          byte_en_blk;
    dcache_pkg::block_u                   wdata_blk;

    // Arrays to controller
    logic                                 sram_hit;
    logic                                 victim_dirty;
    logic [`TAG_BITS-1:0]                 victim_tag;
    dcache_pkg::block_u                   sram_rdata;

    // Memory side
    logic                                 mem_rd;
    logic                                 mem_wr;
    logic [`TAG_BITS+`SET_INDEX_BITS-1:0] mem_block;
    logic [`BLOCK_SIZE_BITS-1:0]          mem_wdata;
    logic                                 mem_done;
    logic [`BLOCK_SIZE_BITS-1:0]          mem_rdata;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .byte_en      (byte_en),
        .sram_hit     (sram_hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .sram_rdata   (sram_rdata),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata),
        .ready        (ready),
        .done         (done),
        .hit          (hit),
        .rdata        (rdata),
        .lookup_en    (lookup_en),
        .store_we     (store_we),
        .fill_we      (fill_we),
        .block_addr   (block_addr),
        .byte_en_blk  (byte_en_blk),
        .wdata_blk    (wdata_blk),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_block    (mem_block),
        .mem_wdata    (mem_wdata)
    );

    dcache_sram u_sram (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .store_we     (store_we),
        .fill_we      (fill_we),
        .block_addr   (block_addr),
        .byte_en_blk  (byte_en_blk),
        .wdata_blk    (wdata_blk),
        .hit          (sram_hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rdata_blk    (sram_rdata)
    );

    main_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_block (mem_block),
        .mem_wdata (mem_wdata),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: verif/dcache_clkgen.sv
// ==========================================================
// Testbench clock, period 20, and active-low reset
// ==========================================================
`default_nettype none

module dcache_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        // Two rising edges under reset, release on a falling edge
        repeat (2) @(negedge clk);
        rst = 1'b1;
    end

    always #10 clk = ~clk;

endmodule

`default_nettype wire

// File: verif/dcache_tb.sv
// ==========================================================
// Data cache testbench driving directed and random loads and
// stores against a shadow memory and a replacement model
// ==========================================================
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb;

    localparam int DIRECTED_OPS = 29;
    localparam int RANDOM_OPS   = 300;
    // A miss with writeback stays well under 40 cycles
    localparam int CYCLE_LIMIT  = (DIRECTED_OPS + RANDOM_OPS) * 40 + 100;
    localparam int SHADOW_WORDS = 1 << (`ADDR_BITS - 2);
    localparam int IDX_LO       = `BLOCK_OFFSET_BITS;
    localparam int TAG_LO       = `BLOCK_OFFSET_BITS + `SET_INDEX_BITS;

    logic                    clk;
    logic                    rst;
    logic                    req;
    logic                    we;
    logic [`ADDR_BITS-1:0]   addr;
    logic [`WORD_BITS-1:0]   wdata;
    logic [`WORD_BITS/8-1:0] byte_en;
    logic                    ready;
    logic                    done;
    logic                    hit;
    logic [`WORD_BITS-1:0]   rdata;

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;

    // Reference model of memory contents plus per-set tags and status
    logic [`WORD_BITS-1:0]     shadow   [SHADOW_WORDS];
    logic                      m_valid  [`SET_NUM][`ASSOCIATIVITY];
    logic [`TAG_BITS-1:0]      m_tag    [`SET_NUM][`ASSOCIATIVITY];
    logic [`ASSOCIATIVITY-1:0] m_status [`SET_NUM];

    dcache_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    dcache_top uut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .we      (we),
        .addr    (addr),
        .wdata   (wdata),
        .byte_en (byte_en),
        .ready   (ready),
        .done    (done),
        .hit     (hit),
        .rdata   (rdata)
    );

    function automatic void flag_mismatch(input string name, input string what,
                                          input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: %s expected %h actual %h", name, what, exp, act);
        errors++;
    endfunction

    function automatic void flag_failure(input string msg);
        $display("Failure: %s", msg);
        errors++;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = i ^ `MEM_INIT_KEY;
        end
        for (int s = 0; s < `SET_NUM; s++) begin
            m_status[s] = '0;
            for (int w = 0; w < `ASSOCIATIVITY; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
    endfunction

    // Way holding the address, or -1 on a miss
    function automatic int model_way(input logic [`ADDR_BITS-1:0] a);
        logic [`SET_INDEX_BITS-1:0] s;
        int way;
        s   = a[TAG_LO-1:IDX_LO];
        way = -1;
        for (int w = 0; w < `ASSOCIATIVITY; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == a[`ADDR_BITS-1:TAG_LO]) begin
                way = w;
            end
        end
        return way;
    endfunction

    // Only the touched way stays marked once the whole set would be marked
    function automatic void mark_used(input logic [`SET_INDEX_BITS-1:0] s, input int way);
        logic [`ASSOCIATIVITY-1:0] used;
        used = `ASSOCIATIVITY'(1) << way;
        if ((m_status[s] | used) == '1) begin
            m_status[s] = used;
        end else begin
            m_status[s] = m_status[s] | used;
        end
    endfunction

    // Fills and stores update status; load hits leave it alone
    function automatic void model_apply(input logic [`ADDR_BITS-1:0] a, input logic is_we,
                                        input logic [31:0] d, input logic [3:0] be);
        logic [`SET_INDEX_BITS-1:0] s;
        int way;
        s   = a[TAG_LO-1:IDX_LO];
        way = model_way(a);
        if (way < 0) begin
            for (int w = `ASSOCIATIVITY - 1; w >= 0; w--) begin
                if (!m_status[s][w]) begin
                    way = w;
                end
            end
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = a[`ADDR_BITS-1:TAG_LO];
            mark_used(s, way);
        end
        if (is_we) begin
            mark_used(s, way);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[a[`ADDR_BITS-1:2]][b*8 +: 8] = d[b*8 +: 8];
                end
            end
        end
    endfunction

    // Called on the done cycle; returns one cycle later, back in idle
    task automatic check_response(input string name, input logic is_we, input logic exp_hit,
                                  input logic [31:0] exp_data, input int lat);
        checks++;
        assert (hit == exp_hit) else flag_mismatch(name, "hit", 32'(exp_hit), 32'(hit));
        if (!is_we) begin
            checks++;
            assert (rdata == exp_data) else flag_mismatch(name, "rdata", exp_data, rdata);
        end
        checks++;
        if (exp_hit) begin
            assert (lat == 2) else flag_mismatch(name, "hit latency", 32'd2, 32'(lat));
        end else begin
            assert (lat > 2)
                else flag_failure($sformatf("%s: miss completed in %0d cycles", name, lat));
        end
        @(negedge clk);
        checks++;
        assert (done == 1'b0 && ready == 1'b1)
            else flag_failure($sformatf("%s: done did not fall back to idle after one cycle",
                                        name));
    endtask

    task automatic access(input string name, input logic is_we, input logic [`ADDR_BITS-1:0] a,
                          input logic [31:0] d, input logic [3:0] be, output logic got_hit);
        logic        exp_hit;
        logic [31:0] exp_data;
        int          lat;
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
        exp_hit = (model_way(a) >= 0);
        model_apply(a, is_we, d, be);
        exp_data = shadow[a[`ADDR_BITS-1:2]];
        req     = 1'b1;
        we      = is_we;
        addr    = a;
        wdata   = d;
        byte_en = be;
        @(negedge clk);
        req = 1'b0;
        lat = 1;
        while (done !== 1'b1) begin
            @(negedge clk);
            lat++;
        end
        got_hit = hit;
        check_response(name, is_we, exp_hit, exp_data, lat);
    endtask

    task automatic expect_hit(input string name, input logic exp, input logic got);
        checks++;
        assert (got == exp) else flag_mismatch(name, "hit", 32'(exp), 32'(got));
    endtask

    // Load miss while a store to another address is offered on alternate busy cycles
    task automatic stray_request_check(input logic [`ADDR_BITS-1:0] a,
                                       input logic [`ADDR_BITS-1:0] stray);
        logic        exp_hit;
        logic [31:0] exp_data;
        int          lat;
        int          extra;
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
        exp_hit = (model_way(a) >= 0);
        model_apply(a, 1'b0, '0, '0);
        exp_data = shadow[a[`ADDR_BITS-1:2]];
        req  = 1'b1;
        we   = 1'b0;
        addr = a;
        @(negedge clk);
        checks++;
        assert (uut.u_ctrl.state != dcache_pkg::IDLE)
            else flag_failure("back_pressure: request was not accepted");
        we      = 1'b1;
        addr    = stray;
        wdata   = 32'hFFFF_FFFF;
        byte_en = 4'hF;
        lat     = 1;
        while (done !== 1'b1) begin
            req = !ready && (lat % 2 == 1);
            @(negedge clk);
            lat++;
        end
        req = 1'b0;
        we  = 1'b0;
        check_response("back_pressure", 1'b0, exp_hit, exp_data, lat);
        extra = 0;
        repeat (2 * `MEM_LATENCY + 6) begin
            @(negedge clk);
            if (done) begin
                extra++;
            end
        end
        checks++;
        assert (extra == 0)
            else flag_mismatch("back_pressure", "extra done pulses", 32'd0, 32'(extra));
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Summary: %0d checks, %0d errors plus timeout", checks, errors);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0]           rnd;
        logic [`ADDR_BITS-1:0] r_addr;
        logic                  r_we;
        logic [3:0]            r_be;
        logic                  got;
        req     = 1'b0;
        we      = 1'b0;
        addr    = '0;
        wdata   = '0;
        byte_en = '0;
        model_reset();
        wait (rst === 1'b1);
        @(negedge clk);

        // After reset
        checks++;
        assert (ready == 1'b1 && done == 1'b0 && uut.u_ctrl.state == dcache_pkg::IDLE)
            else flag_failure("after reset: controller not idle or done already high");
        checks++;
        assert (!uut.mem_rd && !uut.mem_wr && !uut.store_we && !uut.fill_we)
            else flag_failure("after reset: a memory or array strobe is active");
        access("reset_first_load", 1'b0, 12'h040, '0, '0, got);
        expect_hit("reset_first_load", 1'b0, got);
        access("reset_repeat_load", 1'b0, 12'h040, '0, '0, got);
        expect_hit("reset_repeat_load", 1'b1, got);

        // Byte-masked stores into one word, then a neighbour word and a store miss
        access("byte_mask_load", 1'b0, 12'h104, '0, '0, got);
        access("byte_mask_store", 1'b1, 12'h104, 32'hA1B2_C3D4, 4'b0001, got);
        access("byte_mask_load", 1'b0, 12'h104, '0, '0, got);
        access("byte_mask_store", 1'b1, 12'h104, 32'h5566_7788, 4'b0110, got);
        access("byte_mask_load", 1'b0, 12'h104, '0, '0, got);
        access("byte_mask_store", 1'b1, 12'h104, 32'h99AA_BBCC, 4'b1000, got);
        access("byte_mask_load", 1'b0, 12'h104, '0, '0, got);
        access("byte_mask_store", 1'b1, 12'h104, 32'h0F0F_0F0F, 4'b0000, got);
        access("byte_mask_load", 1'b0, 12'h104, '0, '0, got);
        access("byte_mask_neighbour", 1'b1, 12'h108, 32'hDEAD_BEEF, 4'b1111, got);
        access("byte_mask_neighbour_load", 1'b0, 12'h108, '0, '0, got);
        access("byte_mask_load", 1'b0, 12'h104, '0, '0, got);
        access("byte_mask_store_miss", 1'b1, 12'h20C, 32'h1357_9BDF, 4'b1010, got);
        access("byte_mask_load_miss", 1'b0, 12'h20C, '0, '0, got);

        // Two dirty lines in set 5, then tag 2 forces a writeback
        access("dirty_store_t0", 1'b1, 12'h050, 32'hCAFE_0000, 4'b1111, got);
        access("dirty_store_t1", 1'b1, 12'h254, 32'hCAFE_1111, 4'b1111, got);
        access("dirty_evict_t2", 1'b0, 12'h458, '0, '0, got);
        expect_hit("dirty_evict_t2", 1'b0, got);
        access("dirty_reload_t0", 1'b0, 12'h050, '0, '0, got);
        expect_hit("dirty_reload_t0", 1'b0, got);
        access("dirty_reload_t1", 1'b0, 12'h254, '0, '0, got);

        // In set 9 the order A, B, A (store), C must evict B
        access("plru_a", 1'b0, 12'h090, '0, '0, got);
        access("plru_b", 1'b0, 12'h290, '0, '0, got);
        access("plru_a_store", 1'b1, 12'h090, 32'h0A0A_0A0A, 4'b1111, got);
        access("plru_c", 1'b0, 12'h490, '0, '0, got);
        expect_hit("plru_c", 1'b0, got);
        access("plru_a_again", 1'b0, 12'h090, '0, '0, got);
        expect_hit("plru_a_again", 1'b1, got);
        access("plru_b_again", 1'b0, 12'h290, '0, '0, got);
        expect_hit("plru_b_again", 1'b0, got);

        // Ignored requests must leave the stray address untouched
        stray_request_check(12'h6E0, 12'h6E4);
        access("back_pressure_stray", 1'b0, 12'h6E4, '0, '0, got);

        // Random mix over tags 0..3 of sets 0 and 1
        rnd = 32'd40;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd    = xorshift32(rnd);
            r_addr = {1'b0, rnd[1:0], 4'b0000, rnd[2], rnd[4:3], 2'b00};
            r_we   = rnd[5];
            r_be   = rnd[9:6];
            rnd    = xorshift32(rnd);
            access("random_mix", r_we, r_addr, rnd, r_be, got);
        end

        @(negedge clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_sram.sv
rtl/dcache_ctrl.sv
rtl/main_mem.sv
rtl/dcache_top.sv
verif/dcache_clkgen.sv
verif/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module dcache_tb -Mdir obj_dir -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vdcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
